// ==== udp_tx_pkg.sv ====
package udp_tx_pkg;

    localparam int udp_hdr_bytes = 8;
    localparam logic [7:0] udp_proto = 8'd17;

    // source port per frame type
    localparam logic [15:0] src_port_table [0:7] = '{
        16'd55000, 16'd55100, 16'd55200, 16'd55300,
        16'd55400, 16'd55500, 16'd55600, 16'd55700
    };

    localparam int desc_fifo_depth = 4;
    localparam int sum_fifo_depth  = 4;
    localparam int byte_fifo_depth = 2048;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [31:0] dst_ip;
        logic [47:0] dst_mac;
        // pseudo header plus header words, not yet folded
        logic [31:0] hdr_sum;
    } udp_desc_t;

    // end-around carry fold, two passes are enough for 32 bits
    function automatic logic [15:0] csum_fold(input logic [31:0] value);
        logic [16:0] part;
        part = {1'b0, value[31:16]} + {1'b0, value[15:0]};
        part = {1'b0, part[15:0]} + {16'd0, part[16]};
        return part[15:0];
    endfunction

    // invert, an all-zero result goes out as FFFF
    function automatic logic [15:0] csum_finish(input logic [15:0] folded);
        return (folded == 16'hFFFF) ? 16'hFFFF : ~folded;
    endfunction

endpackage

// ==== udp_sync_fifo.sv ====
`timescale 1ns/100ps

module udp_sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 4
) (
    input  logic  sys_clk,
    input  logic  sys_rst_n,
    input  logic  push,
    input  item_t wdata,
    input  logic  pop,
    output item_t rdata,
    output logic  empty,
    output logic  full
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    item_t         mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;

    // head entry is always visible
    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cw'(depth));

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pop |-> !empty);

endmodule

// ==== udp_cfg_regs.sv ====
`timescale 1ns/100ps

module udp_cfg_regs (
    input  logic             sys_clk,
    input  logic             sys_rst_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [2:0]       wb_adr,
    input  logic [31:0]      wb_dat_w,
    output logic [31:0]      wb_dat_r,
    output logic             wb_ack,
    output logic [31:0]      local_ip,
    output logic [31:0]      dst_ip,
    output logic [47:0]      dst_mac,
    output logic [7:0][15:0] dst_ports
);

    logic ack_q;

    // ack is dropped at once if the master lets go of stb
    assign wb_ack = ack_q && wb_cyc && wb_stb;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc && wb_stb && !ack_q;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            local_ip  <= '0;
            dst_ip    <= '0;
            dst_mac   <= '0;
            dst_ports <= '0;
        end else if (wb_ack && wb_we) begin
            case (wb_adr)
                3'd0: local_ip <= wb_dat_w;
                3'd1: dst_ip <= wb_dat_w;
                3'd2: dst_mac[31:0] <= wb_dat_w;
                3'd3: dst_mac[47:32] <= wb_dat_w[15:0];
                // lower type sits in the low half
                3'd4: dst_ports[1:0] <= wb_dat_w;
                3'd5: dst_ports[3:2] <= wb_dat_w;
                3'd6: dst_ports[5:4] <= wb_dat_w;
                default: dst_ports[7:6] <= wb_dat_w;
            endcase
        end
    end

    always_comb begin
        case (wb_adr)
            3'd0: wb_dat_r = local_ip;
            3'd1: wb_dat_r = dst_ip;
            3'd2: wb_dat_r = dst_mac[31:0];
            3'd3: wb_dat_r = {16'd0, dst_mac[47:32]};
            3'd4: wb_dat_r = dst_ports[1:0];
            3'd5: wb_dat_r = dst_ports[3:2];
            3'd6: wb_dat_r = dst_ports[5:4];
            default: wb_dat_r = dst_ports[7:6];
        endcase
    end

    // one ack per request, one cycle after the request was seen
    a_ack_classic: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wb_ack |-> wb_stb && $past(wb_cyc && wb_stb) && !$past(wb_ack));

endmodule

// ==== udp_header_gen.sv ====
`timescale 1ns/100ps

module udp_header_gen (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 tx_req,
    input  logic [2:0]           tx_type,
    input  logic [15:0]          tx_len,
    output logic                 tx_ready,
    input  logic [31:0]          local_ip,
    input  logic [31:0]          dst_ip,
    input  logic [47:0]          dst_mac,
    input  logic [7:0][15:0]     dst_ports,
    input  logic                 desc_pop,
    output udp_tx_pkg::udp_desc_t desc,
    output logic                 desc_empty
);

    import udp_tx_pkg::*;

    logic        busy;
    logic [1:0]  stage;
    logic        accept;
    logic        desc_push;
    logic        desc_full;
    logic [31:0] src_ip_q;
    logic [31:0] dst_ip_q;
    logic [47:0] dst_mac_q;
    logic [15:0] src_port_q;
    logic [15:0] dst_port_q;
    logic [15:0] udp_len_q;
    logic [31:0] acc;
    udp_desc_t   desc_w;

    assign tx_ready  = !busy && !desc_full;
    assign accept    = tx_req && tx_ready;
    // stage 3 is the third cycle after acceptance
    assign desc_push = busy && (stage == 2'd3);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            busy  <= 1'b0;
            stage <= 2'd0;
        end else if (accept) begin
            busy  <= 1'b1;
            stage <= 2'd1;
        end else if (busy) begin
            stage <= stage + 2'd1;
            if (stage == 2'd3) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields, captured so config writes cannot tear a frame
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            src_ip_q   <= local_ip;
            dst_ip_q   <= dst_ip;
            dst_mac_q  <= dst_mac;
            src_port_q <= src_port_table[tx_type];
            dst_port_q <= dst_ports[tx_type];
            udp_len_q  <= tx_len + 16'(udp_hdr_bytes);
        end
    end

    // pseudo header: ip halves first, then protocol, length, source port
    always_ff @(posedge sys_clk) begin
        case (stage)
            2'd1: acc <= 32'(src_ip_q[31:16]) + 32'(src_ip_q[15:0])
                       + 32'(dst_ip_q[31:16]) + 32'(dst_ip_q[15:0]);
            2'd2: acc <= acc + 32'(udp_proto) + 32'(udp_len_q) + 32'(src_port_q);
            default: acc <= acc;
        endcase
    end

    // last two header words go straight into the pushed descriptor
    assign desc_w = '{
        src_port: src_port_q,
        dst_port: dst_port_q,
        udp_len:  udp_len_q,
        dst_ip:   dst_ip_q,
        dst_mac:  dst_mac_q,
        hdr_sum:  acc + 32'(dst_port_q) + 32'(udp_len_q)
    };

    udp_sync_fifo #(
        .item_t(udp_desc_t),
        .depth (desc_fifo_depth)
    ) i_desc_fifo (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .push     (desc_push),
        .wdata    (desc_w),
        .pop      (desc_pop),
        .rdata    (desc),
        .empty    (desc_empty),
        .full     (desc_full)
    );

endmodule

// ==== udp_payload_buffer.sv ====
`timescale 1ns/100ps

module udp_payload_buffer (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        pay_vld,
    input  logic [7:0]  pay_dat,
    input  logic        pay_eop,
    output logic        pay_ready,
    input  logic        byte_pop,
    output logic [8:0]  byte_dat,
    output logic        byte_empty,
    input  logic        sum_pop,
    output logic [31:0] sum,
    output logic        sum_empty
);

    import udp_tx_pkg::*;

    logic        take;
    logic        phase;
    logic [31:0] run_sum;
    logic [31:0] byte_word;
    logic [31:0] next_sum;
    logic [31:0] sum_q;
    logic        sum_push;
    logic        byte_full;
    logic        sum_full;

    // one-cycle gap after eop keeps the sum queue from overrunning
    assign pay_ready = !byte_full && !sum_full && !sum_push;
    assign take      = pay_vld && pay_ready;

    // even bytes are the high half of a word, odd bytes the low half
    assign byte_word = phase ? {24'd0, pay_dat} : {16'd0, pay_dat, 8'd0};
    assign next_sum  = run_sum + byte_word;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            phase    <= 1'b0;
            run_sum  <= '0;
            sum_push <= 1'b0;
        end else begin
            sum_push <= take && pay_eop;
            if (take && pay_eop) begin
                phase   <= 1'b0;
                run_sum <= '0;
            end else if (take) begin
                phase   <= !phase;
                run_sum <= next_sum;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take && pay_eop) begin
            sum_q <= next_sum;
        end
    end

    // frame payload has to fit here, the assembler waits for the sum
    udp_sync_fifo #(
        .item_t(logic [8:0]),
        .depth (byte_fifo_depth)
    ) i_byte_fifo (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .push     (take),
        .wdata    ({pay_eop, pay_dat}),
        .pop      (byte_pop),
        .rdata    (byte_dat),
        .empty    (byte_empty),
        .full     (byte_full)
    );

    udp_sync_fifo #(
        .item_t(logic [31:0]),
        .depth (sum_fifo_depth)
    ) i_sum_fifo (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .push     (sum_push),
        .wdata    (sum_q),
        .pop      (sum_pop),
        .rdata    (sum),
        .empty    (sum_empty),
        .full     (sum_full)
    );

endmodule

// ==== udp_frame_assembler.sv ====
`timescale 1ns/100ps

module udp_frame_assembler (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  udp_tx_pkg::udp_desc_t desc,
    input  logic                  desc_empty,
    output logic                  desc_pop,
    input  logic [31:0]           sum,
    input  logic                  sum_empty,
    output logic                  sum_pop,
    input  logic [8:0]            byte_dat,
    input  logic                  byte_empty,
    output logic                  byte_pop,
    input  logic                  udp_ready,
    output logic                  udp_vld,
    output logic [7:0]            udp_dat,
    output logic                  udp_sop,
    output logic                  udp_eop,
    output logic [31:0]           udp_dst_ip,
    output logic [47:0]           udp_dst_mac,
    output logic [15:0]           udp_len
);

    import udp_tx_pkg::*;

    logic        busy;
    logic        start;
    logic        move;
    logic        hdr_step;
    logic        pay_slot;
    logic        done;
    logic [15:0] cnt;
    logic [15:0] ck_sum;
    logic [15:0] ck_val;
    logic [55:0] hdr_rest;

    assign start    = !busy && !desc_empty && !sum_empty;
    assign desc_pop = start;
    assign sum_pop  = start;
    assign move     = udp_vld && udp_ready;

    // cnt is the index of the byte in the output register
    assign hdr_step = busy && move && (cnt < 16'(udp_hdr_bytes - 1));
    assign pay_slot = busy && (cnt >= 16'(udp_hdr_bytes - 1))
                    && (!udp_vld || (udp_ready && !udp_eop));
    assign byte_pop = pay_slot && !byte_empty;
    assign done     = busy && move && udp_eop;

    // fold each part first so the final add cannot overflow
    assign ck_sum = csum_fold(32'(csum_fold(desc.hdr_sum)) + 32'(csum_fold(sum)));
    assign ck_val = csum_finish(ck_sum);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            busy    <= 1'b0;
            udp_vld <= 1'b0;
            udp_sop <= 1'b0;
            udp_eop <= 1'b0;
        end else if (start) begin
            busy    <= 1'b1;
            udp_vld <= 1'b1;
            udp_sop <= 1'b1;
            udp_eop <= 1'b0;
        end else if (hdr_step) begin
            udp_sop <= 1'b0;
        end else if (byte_pop) begin
            udp_vld <= 1'b1;
            udp_sop <= 1'b0;
            udp_eop <= byte_dat[8];
        end else if (done) begin
            busy    <= 1'b0;
            udp_vld <= 1'b0;
            udp_eop <= 1'b0;
        end else if (pay_slot) begin
            // payload not there yet
            udp_vld <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start) begin
            cnt         <= 16'd0;
            udp_dat     <= desc.src_port[15:8];
            hdr_rest    <= {desc.src_port[7:0], desc.dst_port, desc.udp_len, ck_val};
            udp_dst_ip  <= desc.dst_ip;
            udp_dst_mac <= desc.dst_mac;
            udp_len     <= desc.udp_len;
        end else if (hdr_step) begin
            cnt      <= cnt + 16'd1;
            udp_dat  <= hdr_rest[55:48];
            hdr_rest <= {hdr_rest[47:0], 8'd0};
        end else if (byte_pop) begin
            cnt     <= cnt + 16'd1;
            udp_dat <= byte_dat[7:0];
        end
    end

    // request length and payload eop come from different producers
    a_eop_at_len: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (udp_vld && udp_ready && udp_eop) |-> (cnt == udp_len - 16'd1));

endmodule

// ==== udp_tx_top.sv ====
`timescale 1ns/100ps

module udp_tx_top (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        tx_req,
    input  logic [2:0]  tx_type,
    input  logic [15:0] tx_len,
    output logic        tx_ready,
    input  logic        pay_vld,
    input  logic [7:0]  pay_dat,
    input  logic        pay_eop,
    output logic        pay_ready,
    output logic        udp_vld,
    output logic [7:0]  udp_dat,
    output logic        udp_sop,
    output logic        udp_eop,
    input  logic        udp_ready,
    output logic [31:0] udp_dst_ip,
    output logic [47:0] udp_dst_mac,
    output logic [15:0] udp_len
);

    import udp_tx_pkg::*;

    logic [31:0]       local_ip;
    logic [31:0]       dst_ip;
    logic [47:0]       dst_mac;
    logic [7:0][15:0]  dst_ports;
    udp_desc_t         desc;
    logic              desc_pop;
    logic              desc_empty;
    logic [31:0]       sum;
    logic              sum_pop;
    logic              sum_empty;
    logic [8:0]        byte_dat;
    logic              byte_pop;
    logic              byte_empty;

    udp_cfg_regs i_cfg_regs (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .local_ip (local_ip),
        .dst_ip   (dst_ip),
        .dst_mac  (dst_mac),
        .dst_ports(dst_ports)
    );

    // header and payload paths run side by side
    udp_header_gen i_header_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_req    (tx_req),
        .tx_type   (tx_type),
        .tx_len    (tx_len),
        .tx_ready  (tx_ready),
        .local_ip  (local_ip),
        .dst_ip    (dst_ip),
        .dst_mac   (dst_mac),
        .dst_ports (dst_ports),
        .desc_pop  (desc_pop),
        .desc      (desc),
        .desc_empty(desc_empty)
    );

    udp_payload_buffer i_payload_buffer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pay_vld   (pay_vld),
        .pay_dat   (pay_dat),
        .pay_eop   (pay_eop),
        .pay_ready (pay_ready),
        .byte_pop  (byte_pop),
        .byte_dat  (byte_dat),
        .byte_empty(byte_empty),
        .sum_pop   (sum_pop),
        .sum       (sum),
        .sum_empty (sum_empty)
    );

    udp_frame_assembler i_frame_assembler (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .desc       (desc),
        .desc_empty (desc_empty),
        .desc_pop   (desc_pop),
        .sum        (sum),
        .sum_empty  (sum_empty),
        .sum_pop    (sum_pop),
        .byte_dat   (byte_dat),
        .byte_empty (byte_empty),
        .byte_pop   (byte_pop),
        .udp_ready  (udp_ready),
        .udp_vld    (udp_vld),
        .udp_dat    (udp_dat),
        .udp_sop    (udp_sop),
        .udp_eop    (udp_eop),
        .udp_dst_ip (udp_dst_ip),
        .udp_dst_mac(udp_dst_mac),
        .udp_len    (udp_len)
    );

endmodule

// ==== tb_udp_tx_top.sv ====
`timescale 1ns/100ps

module tb_udp_tx_top;

    localparam int clk_period   = 4;
    localparam int hdr_bytes    = 8;
    localparam int frame_count  = 17;
    localparam int max_payload  = 48;
    // every frame gets four cycles per byte plus slack for back-pressure
    localparam int cycle_budget = frame_count * (max_payload + hdr_bytes + 24) * 4 + 400;
    localparam int watchdog_ns  = cycle_budget * clk_period;
    localparam logic [31:0] seed = 32'd48144;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        tx_req;
    logic [2:0]  tx_type;
    logic [15:0] tx_len;
    logic        tx_ready;
    logic        pay_vld;
    logic [7:0]  pay_dat;
    logic        pay_eop;
    logic        pay_ready;
    logic        udp_vld;
    logic [7:0]  udp_dat;
    logic        udp_sop;
    logic        udp_eop;
    logic        udp_ready;
    logic [31:0] udp_dst_ip;
    logic [47:0] udp_dst_mac;
    logic [15:0] udp_len;

    logic [31:0] cfg_word [8];
    logic [15:0] port_cfg [8];
    logic [31:0] dst_ip_cfg;
    logic [47:0] dst_mac_cfg;
    logic [31:0] rand_state;
    logic        bp_on;
    logic        move;

    // expected output entry: udp_len, sop, eop, data
    logic [25:0] exp_q [$];
    logic [25:0] exp_head;
    logic        exp_avail;
    logic [8:0]  pay_q [$];
    logic [2:0]  rq_type [$];
    logic [15:0] rq_len [$];

    udp_tx_top i_udp_tx_top (.*);

    assign move = udp_vld && udp_ready;

    initial begin
        sys_clk = 1'b0;
        forever #(clk_period / 2) sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    function automatic logic [15:0] ones_fold(input logic [31:0] value);
        logic [31:0] s;
        s = value;
        while (s[31:16] != 16'd0) begin
            s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
        end
        return s[15:0];
    endfunction

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        @(negedge sys_clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do @(negedge sys_clk); while (!wb_ack);
        rdat = wb_dat_r;
        // transfer completes on the coming rising edge
        @(negedge sys_clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // write cycle that the master gives up before the slave answers
    task automatic bus_abort(input logic [2:0] adr, input logic [31:0] wdat);
        @(negedge sys_clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge sys_clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // payload plus the expected header and byte stream of one frame
    task automatic plan_frame(input int ftype, input int len, input bit zero_ck);
        logic [7:0]  pay [$];
        logic [7:0]  hdr [8];
        logic [31:0] acc;
        logic [15:0] ulen;
        logic [15:0] sport;
        logic [15:0] dport;
        logic [15:0] ck;
        logic [15:0] fill;
        int          i;
        ulen  = 16'(len + hdr_bytes);
        sport = 16'(55000 + 100 * ftype);
        dport = port_cfg[ftype];
        acc = 32'(cfg_word[0][31:16]) + 32'(cfg_word[0][15:0])
            + 32'(cfg_word[1][31:16]) + 32'(cfg_word[1][15:0])
            + 32'd17 + 32'(ulen) + 32'(sport) + 32'(dport) + 32'(ulen);
        if (zero_ck) begin
            // two bytes that top the folded sum up to all ones
            fill = ~ones_fold(acc);
            pay.push_back(fill[15:8]);
            pay.push_back(fill[7:0]);
        end else begin
            for (i = 0; i < len; i++) begin
                pay.push_back(8'(next_rand()));
            end
        end
        for (i = 0; i < len; i++) begin
            acc += (i % 2 == 0) ? {16'd0, pay[i], 8'd0} : {24'd0, pay[i]};
            pay_q.push_back({i == len - 1, pay[i]});
        end
        ck = ~ones_fold(acc);
        if (ck == 16'h0000) begin
            ck = 16'hFFFF;
        end
        hdr = '{sport[15:8], sport[7:0], dport[15:8], dport[7:0],
                ulen[15:8], ulen[7:0], ck[15:8], ck[7:0]};
        for (i = 0; i < hdr_bytes; i++) begin
            exp_q.push_back({ulen, i == 0, 1'b0, hdr[i]});
        end
        for (i = 0; i < len; i++) begin
            exp_q.push_back({ulen, 1'b0, i == len - 1, pay[i]});
        end
        rq_type.push_back(3'(ftype));
        rq_len.push_back(16'(len));
    endtask

    // tx_ready comes from registers, so its value at the falling edge holds
    task automatic issue_requests();
        while (rq_type.size() != 0) begin
            @(negedge sys_clk);
            if (tx_ready) begin
                tx_req  = 1'b1;
                tx_type = rq_type.pop_front();
                tx_len  = rq_len.pop_front();
            end else begin
                tx_req = 1'b0;
            end
        end
        @(negedge sys_clk);
        tx_req = 1'b0;
    endtask

    task automatic stream_payload();
        logic [31:0] r;
        while (pay_q.size() != 0) begin
            @(negedge sys_clk);
            r = next_rand();
            if (pay_ready && r[1:0] != 2'b00) begin
                {pay_eop, pay_dat} = pay_q.pop_front();
                pay_vld = 1'b1;
            end else begin
                pay_vld = 1'b0;
            end
        end
        @(negedge sys_clk);
        pay_vld = 1'b0;
        pay_eop = 1'b0;
    endtask

    task automatic run_batch(input logic bp);
        bp_on = bp;
        fork
            issue_requests();
            stream_payload();
        join
        while (exp_q.size() != 0) begin
            @(negedge sys_clk);
        end
        bp_on = 1'b0;
    endtask

    // separate random stream for back-pressure
    initial begin
        logic [31:0] bp_state;
        bp_state  = ~seed;
        udp_ready = 1'b1;
        forever begin
            @(negedge sys_clk);
            if (bp_on) begin
                bp_state  = xorshift32(bp_state);
                udp_ready = (bp_state[2:0] > 3'd2);
            end else begin
                udp_ready = 1'b1;
            end
        end
    end

    // reference queue advances on every byte that moves
    always @(posedge sys_clk) begin
        if (sys_rst_n && move && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        exp_avail <= (exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end else begin
            exp_head <= '0;
        end
    end

    a_expected: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        move |-> exp_avail)
        else report_error("byte moved while none was expected");

    a_data: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        move |-> udp_dat == exp_head[7:0])
        else report_error($sformatf("udp_dat %h, expected %h",
                                    $sampled(udp_dat), $sampled(exp_head[7:0])));

    a_marks: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        move |-> {udp_sop, udp_eop} == exp_head[9:8])
        else report_error($sformatf("sop/eop %b, expected %b",
                                    $sampled({udp_sop, udp_eop}), $sampled(exp_head[9:8])));

    a_len: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        move |-> udp_len == exp_head[25:10])
        else report_error($sformatf("udp_len %0d, expected %0d",
                                    $sampled(udp_len), $sampled(exp_head[25:10])));

    a_dest: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        move |-> udp_dst_ip == dst_ip_cfg && udp_dst_mac == dst_mac_cfg)
        else report_error("destination ip or mac differs from configuration");

    a_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        udp_vld && !udp_ready |=> udp_vld && $stable(udp_dat) && $stable(udp_sop)
                                  && $stable(udp_eop))
        else report_error("output changed while waiting for udp_ready");

    a_ack_stb: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else report_error("wb_ack high without cyc and stb");

    a_ack_next: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(wb_stb) ##1 wb_stb |-> wb_ack)
        else report_error("wb_ack missing in the cycle after stb");

    a_ack_once: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wb_ack |=> !wb_ack)
        else report_error("wb_ack held for more than one cycle");

    initial begin
        #(watchdog_ns);
        $display("timeout: frames still pending after %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          i;
        int          len;
        logic [31:0] rd;
        rand_state = seed;
        bp_on      = 1'b0;
        sys_rst_n  = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        tx_req     = 1'b0;
        tx_type    = '0;
        tx_len     = '0;
        pay_vld    = 1'b0;
        pay_dat    = '0;
        pay_eop    = 1'b0;

        cfg_word[0] = 32'hC0A8_0105;
        cfg_word[1] = 32'hC0A8_01C8;
        cfg_word[2] = 32'h5E00_FACE;
        cfg_word[3] = 32'h0000_0211;
        for (i = 0; i < 8; i++) begin
            port_cfg[i] = 16'd5000 + 16'(i) * 16'd1031;
        end
        for (i = 0; i < 4; i++) begin
            cfg_word[4 + i] = {port_cfg[2 * i + 1], port_cfg[2 * i]};
        end
        dst_ip_cfg  = cfg_word[1];
        dst_mac_cfg = {cfg_word[3][15:0], cfg_word[2]};

        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
        assert (tx_ready && pay_ready && !udp_vld && !udp_sop && !udp_eop && !wb_ack)
            else report_error("outputs not at their reset values");

        for (i = 0; i < 8; i++) begin
            bus_access(1'b1, 3'(i), cfg_word[i], rd);
        end
        // an abandoned write must leave the register alone
        bus_abort(3'd2, ~cfg_word[2]);
        for (i = 0; i < 8; i++) begin
            bus_access(1'b0, 3'(i), 32'd0, rd);
            assert (rd == cfg_word[i])
                else report_error($sformatf("word %0d reads %h, expected %h",
                                            i, rd, cfg_word[i]));
        end

        // one frame per type, short odd and even payloads first
        for (i = 0; i < 8; i++) begin
            if (i == 0) begin
                len = 1;
            end else if (i == 1) begin
                len = 2;
            end else if (i == 2) begin
                len = max_payload - 1;
            end else begin
                len = 3 + int'(next_rand() % 40);
            end
            plan_frame(i, len, 1'b0);
            run_batch(1'b0);
        end

        // checksum that folds to zero goes out as FFFF
        plan_frame(5, 2, 1'b1);
        run_batch(1'b0);

        // four frames queued back to back under back-pressure
        repeat (2) begin
            for (i = 0; i < 4; i++) begin
                plan_frame(int'(next_rand() % 8), 1 + int'(next_rand() % max_payload), 1'b0);
            end
            run_batch(1'b1);
        end

        repeat (4) @(negedge sys_clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
udp_tx_pkg.sv
udp_sync_fifo.sv
udp_cfg_regs.sv
udp_header_gen.sv
udp_payload_buffer.sv
udp_frame_assembler.sv
udp_tx_top.sv
tb_udp_tx_top.sv

// ==== Makefile ====
TOP := tb_udp_tx_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
